//--- corr_pkg.sv
/* lag correlator shared definitions.
   sizes of the delay lines and counter bank, the counter word and the readout states. */

package corr_pkg;

	// ------------------------------------------------------------------
	// array sizes
	// ------------------------------------------------------------------

	// number of 1-bit sampled inputs.
	localparam int NUM_INPUTS = 4;

	// one more than the largest lag magnitude, so lags run -1 .. +1.
	localparam int LAG_CROSS = 2;

	// taps kept per input, depth 0 holds the newest sample.
	localparam int LAG_SPAN = 2 * LAG_CROSS - 1;

	// lags per baseline.
	localparam int NUM_LAGS = 2 * LAG_CROSS - 1;

	// pairs a<b.
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;

	// counters in all, baseline number times NUM_LAGS plus lag position.
	localparam int NUM_ACC = NUM_BASELINES * NUM_LAGS;

	// ------------------------------------------------------------------
	// counter word
	// ------------------------------------------------------------------

	localparam int RESOLUTION = 10;
	localparam int ACC_IDX_W = 5;

	typedef logic [RESOLUTION-1:0] acc_t;

	// counters stop here and hold.
	localparam acc_t ACC_MAX = {RESOLUTION{1'b1}};

	// ------------------------------------------------------------------
	// readout sequencing
	// ------------------------------------------------------------------

	typedef enum logic {
		READOUT_IDLE,
		READOUT_SCAN
	} readout_state_e;

endpackage

//--- sample_delay_lines.sv
/* sample delay lines.
   shifts each input's 1-bit samples into a short tap register on the sample strobe. */

`timescale 1ns/1ps

module sample_delay_lines (
	input  logic                                             pllclk,
	input  logic                                             reset,
	input  logic                                             smp_en,
	input  logic [corr_pkg::NUM_INPUTS-1:0]                  adc_data,
	output logic [corr_pkg::NUM_INPUTS*corr_pkg::LAG_SPAN-1:0] taps,
	output logic                                             tap_valid
);

	import corr_pkg::*;

	// taps for input i sit at bits i*LAG_SPAN .. i*LAG_SPAN+LAG_SPAN-1.
	// bit k of that slice is the sample k strobes old.

	genvar i;

	generate
		for (i = 0; i < NUM_INPUTS; i++) begin : g_line
			logic [LAG_SPAN-1:0] line_q;

			always_ff @(posedge pllclk) begin
				if (!reset) begin
					line_q <= '0;
				end else if (smp_en) begin
					line_q <= {line_q[LAG_SPAN-2:0], adc_data[i]};
				end
			end

			assign taps[i*LAG_SPAN +: LAG_SPAN] = line_q;
		end
	endgenerate

	// the qualifier follows the strobe by one edge, in step with the taps.
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			tap_valid <= 1'b0;
		end else begin
			tap_valid <= smp_en;
		end
	end

endmodule

//--- correlation_bank.sv
/* coincidence counter bank.
   one saturating counter per baseline and lag, restarted by the snapshot pulse. */

`timescale 1ns/1ps

module correlation_bank (
	input  logic                                             pllclk,
	input  logic                                             reset,
	input  logic [corr_pkg::NUM_INPUTS*corr_pkg::LAG_SPAN-1:0] taps,
	input  logic                                             tap_valid,
	input  logic [corr_pkg::NUM_INPUTS-1:0]                  mask,
	input  logic                                             snap,
	output corr_pkg::acc_t                                   acc_values [corr_pkg::NUM_ACC]
);

	import corr_pkg::*;

	// ------------------------------------------------------------------
	// baseline and lag decode
	// ------------------------------------------------------------------

	// input a is always taken at the middle depth, input b at depth 1+d.
	// with lag position p = d+1 that makes b's depth simply p.
	localparam int REF_DEPTH = LAG_CROSS - 1;

	genvar a, b, p;

	generate
		for (a = 0; a < NUM_INPUTS; a++) begin : g_a
			for (b = a + 1; b < NUM_INPUTS; b++) begin : g_b
				// baselines are numbered (0,1), (0,2), .. (2,3).
				localparam int BASELINE = a * NUM_INPUTS - a * (a + 1) / 2 + (b - a - 1);

				logic pair_on;

				// a masked input takes no part in any of its baselines.
				assign pair_on = tap_valid & ~mask[a] & ~mask[b];

				for (p = 0; p < NUM_LAGS; p++) begin : g_lag
					localparam int IDX = BASELINE * NUM_LAGS + p;

					logic hit;
					acc_t count_q;

					assign hit = pair_on & taps[a*LAG_SPAN + REF_DEPTH] & taps[b*LAG_SPAN + p];

					// ------------------------------------------------------
					// saturating counter
					// ------------------------------------------------------

					always_ff @(posedge pllclk) begin
						if (!reset) begin
							count_q <= '0;
						end else if (snap) begin
							// this cycle's coincidence opens the new integration.
							count_q <= acc_t'(hit);
						end else if (hit && (count_q != ACC_MAX)) begin
							count_q <= count_q + 1'b1;
						end
					end

					assign acc_values[IDX] = count_q;
				end
			end
		end
	endgenerate

endmodule

//--- accum_readout.sv
/* counter readout.
   takes a snapshot of the bank on an accepted dump and scans it out one word per cycle. */

`timescale 1ns/1ps

module accum_readout (
	input  logic                          pllclk,
	input  logic                          reset,
	input  logic                          dump,
	input  corr_pkg::acc_t                acc_values [corr_pkg::NUM_ACC],
	output logic                          snap,
	output logic                          out_valid,
	output logic [corr_pkg::ACC_IDX_W-1:0] out_index,
	output corr_pkg::acc_t                out_value,
	output logic                          busy
);

	import corr_pkg::*;

	readout_state_e state_q;
	logic [ACC_IDX_W-1:0] idx_q;
	acc_t snapshot_q [NUM_ACC];

	// a dump is only taken while idle, anything during a frame is dropped.
	assign snap = dump && (state_q == READOUT_IDLE);

	// ------------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------------

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state_q <= READOUT_IDLE;
			idx_q <= '0;
		end else begin
			case (state_q)
				READOUT_IDLE: begin
					if (dump) begin
						state_q <= READOUT_SCAN;
						idx_q <= '0;
					end
				end
				READOUT_SCAN: begin
					if (idx_q == ACC_IDX_W'(NUM_ACC - 1)) begin
						state_q <= READOUT_IDLE;
						idx_q <= '0;
					end else begin
						idx_q <= idx_q + 1'b1;
					end
				end
				default: begin
					state_q <= READOUT_IDLE;
					idx_q <= '0;
				end
			endcase
		end
	end

	// the bank still shows the closing totals during the snap cycle.
	always_ff @(posedge pllclk) begin
		if (snap) begin
			snapshot_q <= acc_values;
		end
	end

	// ------------------------------------------------------------------
	// output words
	// ------------------------------------------------------------------

	assign out_valid = (state_q == READOUT_SCAN);
	assign busy = (state_q == READOUT_SCAN);
	assign out_index = idx_q;
	assign out_value = snapshot_q[idx_q];

endmodule

//--- correlator_top.sv
/* lag correlator top level.
   four 1-bit inputs, 18 coincidence counters and a word-serial readout. */

`timescale 1ns/1ps

module correlator_top (
	input  logic                           pllclk,
	input  logic                           reset,
	input  logic                           smp_en,
	input  logic [corr_pkg::NUM_INPUTS-1:0] adc_data,
	input  logic [corr_pkg::NUM_INPUTS-1:0] mask,
	input  logic                           dump,
	output logic                           out_valid,
	output logic [corr_pkg::ACC_IDX_W-1:0]  out_index,
	output corr_pkg::acc_t                 out_value,
	output logic                           busy
);

	import corr_pkg::*;

	logic [NUM_INPUTS*LAG_SPAN-1:0] taps;
	logic tap_valid;
	logic snap;
	acc_t acc_values [NUM_ACC];

	sample_delay_lines u_delay (
		.pllclk    (pllclk),
		.reset     (reset),
		.smp_en    (smp_en),
		.adc_data  (adc_data),
		.taps      (taps),
		.tap_valid (tap_valid)
	);

	correlation_bank u_bank (
		.pllclk     (pllclk),
		.reset      (reset),
		.taps       (taps),
		.tap_valid  (tap_valid),
		.mask       (mask),
		.snap       (snap),
		.acc_values (acc_values)
	);

	accum_readout u_readout (
		.pllclk     (pllclk),
		.reset      (reset),
		.dump       (dump),
		.acc_values (acc_values),
		.snap       (snap),
		.out_valid  (out_valid),
		.out_index  (out_index),
		.out_value  (out_value),
		.busy       (busy)
	);

endmodule

//--- tb_correlator.sv
/* lag correlator testbench.
   drives random 1-bit samples, dumps the counters and checks each frame against a counting model. */

`timescale 1ns/1ps

module tb_correlator;

	import corr_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_CYCLES = 300;
	localparam int SAT_CYCLES = 1100;
	localparam int BUSY_FEED = 30;
	localparam int FRAME_WAIT = 40;
	localparam int TAIL_CYCLES = 20;
	localparam int SAT_VALUE = (1 << RESOLUTION) - 1;

	// the tests take about 2,000 cycles, so this leaves ample margin.
	localparam int CYCLE_LIMIT = 4000;

	logic pllclk;
	logic reset;
	logic smp_en;
	logic [NUM_INPUTS-1:0] adc_data;
	logic [NUM_INPUTS-1:0] mask;
	logic dump;
	logic out_valid;
	logic [ACC_IDX_W-1:0] out_index;
	acc_t out_value;
	logic busy;

	logic [31:0] rng_state = 32'd52;
	int cycle_count = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int busy_cycles = 0;

	logic [NUM_INPUTS-1:0] cur_mask;
	logic [LAG_SPAN-1:0] history [NUM_INPUTS];
	acc_t model_count [NUM_ACC];
	acc_t frame_expect [NUM_ACC];

	int word_index [$];
	acc_t word_value [$];

	correlator_top dut (
		.pllclk    (pllclk),
		.reset     (reset),
		.smp_en    (smp_en),
		.adc_data  (adc_data),
		.mask      (mask),
		.dump      (dump),
		.out_valid (out_valid),
		.out_index (out_index),
		.out_value (out_value),
		.busy      (busy)
	);

	initial pllclk = 1'b0;
	always #50 pllclk = ~pllclk;

	always @(posedge pllclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	// words are taken at the falling edge, well away from the DUT's updates.
	always @(negedge pllclk) begin
		if (reset && out_valid) begin
			word_index.push_back(out_index);
			word_value.push_back(out_value);
		end
		if (reset && busy) begin
			busy_cycles++;
		end
	end

	// ------------------------------------------------------------------
	// stimulus and model
	// ------------------------------------------------------------------

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic model_sample(input logic [NUM_INPUTS-1:0] data);
		int n;
		int idx;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			history[i] = {history[i][LAG_SPAN-2:0], data[i]};
		end
		n = 0;
		for (int a = 0; a < NUM_INPUTS; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				// input a at depth 1, input b at depth p for lag p-1.
				for (int p = 0; p < NUM_LAGS; p++) begin
					idx = n * NUM_LAGS + p;
					if (!cur_mask[a] && !cur_mask[b] && history[a][1] && history[b][p]
							&& model_count[idx] != SAT_VALUE) begin
						model_count[idx] = model_count[idx] + 1;
					end
				end
				n++;
			end
		end
	endtask

	task automatic drive_cycle(input logic smp, input logic [NUM_INPUTS-1:0] data,
			input logic dmp);
		@(posedge pllclk);
		smp_en <= smp;
		adc_data <= data;
		mask <= cur_mask;
		dump <= dmp;
		if (smp) begin
			model_sample(data);
		end
	endtask

	task automatic run_random(input int cycles);
		logic [31:0] r;
		for (int i = 0; i < cycles; i++) begin
			r = next_random();
			drive_cycle(r[0], r[NUM_INPUTS:1], 1'b0);
		end
	endtask

	task automatic do_dump();
		word_index.delete();
		word_value.delete();
		busy_cycles = 0;
		drive_cycle(1'b0, '0, 1'b1);
		for (int i = 0; i < NUM_ACC; i++) begin
			frame_expect[i] = model_count[i];
			model_count[i] = '0;
		end
	endtask

	// ------------------------------------------------------------------
	// checking
	// ------------------------------------------------------------------

	task automatic check_frame(input string name);
		int waited;
		int n;
		waited = 0;
		while (word_value.size() < NUM_ACC && waited < FRAME_WAIT) begin
			drive_cycle(1'b0, '0, 1'b0);
			waited++;
		end
		// idle a while longer so that any extra word is caught.
		repeat (TAIL_CYCLES) drive_cycle(1'b0, '0, 1'b0);
		assert (word_value.size() == NUM_ACC) else begin
			$display("%s: readout gave %0d words where %0d were due", name,
				word_value.size(), NUM_ACC);
			test_errors++;
		end
		// busy covers exactly the cycles of the frame.
		assert (busy_cycles == NUM_ACC) else begin
			$display("Mismatch %s busy cycles: expected %0d actual %0d", name, NUM_ACC,
				busy_cycles);
			test_errors++;
		end
		n = (word_value.size() < NUM_ACC) ? word_value.size() : NUM_ACC;
		for (int i = 0; i < n; i++) begin
			assert (word_index[i] == i) else begin
				$display("Mismatch %s word %0d index: expected %0d actual %0d", name, i, i,
					word_index[i]);
				test_errors++;
			end
			assert (word_value[i] == frame_expect[i]) else begin
				$display("Mismatch %s index %0d: expected %0d actual %0d", name, i,
					frame_expect[i], word_value[i]);
				test_errors++;
			end
		end
		word_index.delete();
		word_value.delete();
		busy_cycles = 0;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("test %-12s %s (%0d errors)", name, (test_errors == 0) ? "passed" : "FAILED",
			test_errors);
		total_errors += test_errors;
		test_errors = 0;
	endtask

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------

	initial begin
		reset <= 1'b0;
		smp_en <= 1'b0;
		adc_data <= '0;
		mask <= '0;
		dump <= 1'b0;
		cur_mask = '0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			history[i] = '0;
		end
		for (int i = 0; i < NUM_ACC; i++) begin
			model_count[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge pllclk);
		reset <= 1'b1;

		@(negedge pllclk);
		assert (!out_valid && !busy) else begin
			$display("reset_state: out_valid or busy is high after reset");
			test_errors++;
		end
		repeat (4) drive_cycle(1'b0, '0, 1'b0);
		do_dump();
		check_frame("reset_state");
		finish_test("reset_state");

		run_random(RANDOM_CYCLES);
		repeat (4) drive_cycle(1'b0, '0, 1'b0);
		do_dump();
		check_frame("random");
		finish_test("random");

		cur_mask = next_random() & 32'hf;
		if (cur_mask == '0) begin
			cur_mask = 4'b0100;
		end
		run_random(RANDOM_CYCLES);
		repeat (4) drive_cycle(1'b0, '0, 1'b0);
		do_dump();
		check_frame("masking");
		finish_test("masking");

		cur_mask = '0;
		repeat (SAT_CYCLES) drive_cycle(1'b1, '1, 1'b0);
		repeat (4) drive_cycle(1'b0, '0, 1'b0);
		do_dump();
		check_frame("saturation");
		finish_test("saturation");

		// the second dump lands in the middle of the first frame.
		do_dump();
		for (int i = 0; i < BUSY_FEED; i++) begin
			drive_cycle(next_random() & 1, next_random() & 32'hf, i == 6);
		end
		check_frame("dump_busy");
		repeat (4) drive_cycle(1'b0, '0, 1'b0);
		do_dump();
		check_frame("dump_busy");
		finish_test("dump_busy");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
corr_pkg.sv
sample_delay_lines.sv
correlation_bank.sv
accum_readout.sv
correlator_top.sv
tb_correlator.sv

//--- Bender.yml
package:
  name: lag_correlator

sources:
  - files:
      - corr_pkg.sv
      - sample_delay_lines.sv
      - correlation_bank.sv
      - accum_readout.sv
      - correlator_top.sv
  - target: test
    files:
      - tb_correlator.sv
